// File: source/ifPkg.sv
package ifPkg;

   // Basic widths of the instruction front end
   typedef logic [31:0] wordT;
   typedef logic [31:0] addrT;
   typedef logic [5:0]  opcT;
   typedef logic [4:0]  regT;
   typedef logic [15:0] immT;
   typedef logic [10:0] altT;

   // Primary opcodes, octal as in the ISA tables
   localparam opcT opcImm  = 6'o54;
   localparam opcT opcRtd  = 6'o55;
   localparam opcT opcBra  = 6'o46;
   localparam opcT opcBraI = 6'o56;
   localparam opcT opcBcc  = 6'o47;
   localparam opcT opcBccI = 6'o57;
   localparam opcT opcMul  = 6'o20;
   localparam opcT opcMulI = 6'o30;
   localparam opcT opcBsf  = 6'o21;
   localparam opcT opcBsfI = 6'o31;

   // brali r14, 0x10
   // ra field 0x0C selects absolute target plus link
   localparam wordT intOp = {opcBraI, 5'd14, 5'h0c, 16'h0010};

   // Stall lengths after multicycle ops
   localparam int stallW = 2;
   typedef logic [stallW-1:0] stallCntT;
   localparam stallCntT mulStall = 2'd3;
   localparam stallCntT bsfStall = 2'd2;

   // First fetch address
   localparam addrT resetPc = 32'h0000_0000;

   // Fetch sequencer states
   typedef enum logic [1:0] {
      fsIdle,
      fsReq,
      fsHold
   } fetchStateT;

   // Low half of a word, either rb/alt or a 16-bit immediate
   typedef struct packed {
      regT rb;
      altT alt;
   } rbAltT;

   typedef union packed {
      rbAltT f;
      immT   imm;
   } lowT;

   // Decoded instruction handed downstream
   typedef struct packed {
      opcT  opc;
      regT  rd;
      regT  ra;
      lowT  low;
      wordT simm;
   } decodeT;

endpackage

// File: source/fetchCtrl.sv
`timescale 1ns/1ns

module fetchCtrl (
   input  logic        gclk,
   input  logic        grst,
   input  logic        stall,
   input  logic        wbAck,
   input  ifPkg::wordT wbDatIn,
   output ifPkg::addrT wbAdr,
   output logic        wbCyc,
   output logic        wbStb,
   output logic        insnStrobe,
   output ifPkg::wordT insnWord
);

   ifPkg::fetchStateT state;
   ifPkg::fetchStateT stateNext;
   ifPkg::addrT       pc;

   // Bus request is live only in fsReq
   // cyc and stb share one source so they rise and fall together
   assign wbCyc = (state == ifPkg::fsReq);
   assign wbStb = (state == ifPkg::fsReq);

   // pc only moves on ack, so the address is steady through wait states
   assign wbAdr = pc;

   // Word accepted in the ack cycle
   assign insnStrobe = wbCyc & wbAck;
   assign insnWord   = wbDatIn;

   always_comb begin
      stateNext = state;
      unique case (state)
         ifPkg::fsIdle: begin
            // Leave idle right after reset
            stateNext = ifPkg::fsReq;
         end
         ifPkg::fsReq: begin
            // Hold request until the slave answers
            if (wbAck) begin
               stateNext = ifPkg::fsHold;
            end
         end
         ifPkg::fsHold: begin
            // At least one idle bus cycle, longer while stalled
            if (!stall) begin
               stateNext = ifPkg::fsReq;
            end
         end
         default: begin
            stateNext = ifPkg::fsIdle;
         end
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         state <= ifPkg::fsIdle;
         pc    <= ifPkg::resetPc;
      end else begin
         state <= stateNext;
         // Sequential fetch only, no branch targets here
         if (insnStrobe) begin
            pc <= pc + 32'd4;
         end
      end
   end

endmodule

// File: source/stallTimer.sv
`timescale 1ns/1ns

module stallTimer (
   input  logic       gclk,
   input  logic       grst,
   input  logic       decValid,
   input  ifPkg::opcT opc,
   output logic       stall
);

   ifPkg::stallCntT count;
   logic            isMul;
   logic            isBsf;

   // Register and immediate forms both take the long path
   assign isMul = (opc == ifPkg::opcMul) || (opc == ifPkg::opcMulI);
   assign isBsf = (opc == ifPkg::opcBsf) || (opc == ifPkg::opcBsfI);

   // High for exactly the loaded count
   assign stall = (count != '0);

   always_ff @(posedge gclk) begin
      if (grst) begin
         count <= '0;
      end else if (decValid && isMul) begin
         count <= ifPkg::mulStall;
      end else if (decValid && isBsf) begin
         count <= ifPkg::bsfStall;
      end else if (count != '0) begin
         // Drain one per cycle
         count <= count - 1'b1;
      end
   end

endmodule

// File: source/intLatch.sv
`timescale 1ns/1ns

module intLatch (
   input  logic gclk,
   input  logic grst,
   input  logic intReq,
   input  logic intEnable,
   input  logic intTaken,
   output logic intPending
);

   // Two synchronizer stages plus one for the edge
   logic [2:0] sync;
   logic       intRise;

   // Rising edge of the synchronized level
   assign intRise = sync[1] & ~sync[2];

   always_ff @(posedge gclk) begin
      if (grst) begin
         sync       <= '0;
         intPending <= 1'b0;
      end else if (intEnable) begin
         sync <= {sync[1:0], intReq};
         // A new edge wins over a same-cycle clear
         intPending <= (intPending & ~intTaken) | intRise;
      end else begin
         // Masked: synchronizer frozen, nothing pending
         intPending <= 1'b0;
      end
   end

endmodule

// File: source/instBuffer.sv
`timescale 1ns/1ns

module instBuffer (
   input  logic          gclk,
   input  logic          grst,
   input  logic          insnStrobe,
   input  ifPkg::wordT   insnWord,
   input  logic          intPending,
   output ifPkg::decodeT dec,
   output logic          decValid,
   output logic          intTaken
);

   ifPkg::wordT   nextWord;
   ifPkg::decodeT decNext;
   ifPkg::opcT    nextOpc;
   logic          inject;
   logic          prevImm;
   logic          blockInt;
   logic          nextImm;
   logic          nextRtd;
   logic          nextBru;
   logic          nextBcc;

   // No injection into a delay slot or between IMM and its user
   assign inject = intPending & ~blockInt;

   // Fetched word is dropped when the interrupt takes its place
   assign nextWord = inject ? ifPkg::intOp : insnWord;
   assign nextOpc  = nextWord[31:26];

   // Classify what is about to be decoded
   assign nextImm = (nextOpc == ifPkg::opcImm);
   assign nextRtd = (nextOpc == ifPkg::opcRtd);
   assign nextBru = (nextOpc == ifPkg::opcBra) || (nextOpc == ifPkg::opcBraI);
   assign nextBcc = (nextOpc == ifPkg::opcBcc) || (nextOpc == ifPkg::opcBccI);

   always_comb begin
      decNext.opc     = nextWord[31:26];
      decNext.rd      = nextWord[25:21];
      decNext.ra      = nextWord[20:16];
      decNext.low.imm = nextWord[15:0];
      // IMM prefix supplies the upper half still held in dec
      if (prevImm) begin
         decNext.simm = {dec.low.imm, nextWord[15:0]};
      end else begin
         decNext.simm = {{16{nextWord[15]}}, nextWord[15:0]};
      end
   end

   // Decode payload loaded on each strobe
   always_ff @(posedge gclk) begin
      if (insnStrobe) begin
         dec <= decNext;
      end
   end

   // Control flags follow the last decoded opcode
   always_ff @(posedge gclk) begin
      if (grst) begin
         decValid <= 1'b0;
         intTaken <= 1'b0;
         prevImm  <= 1'b0;
         blockInt <= 1'b0;
      end else begin
         decValid <= insnStrobe;
         // Tells the latch to drop the request
         intTaken <= insnStrobe & inject;
         if (insnStrobe) begin
            prevImm  <= nextImm;
            blockInt <= nextImm | nextRtd | nextBru | nextBcc;
         end
      end
   end

endmodule

// File: source/fetchTop.sv
`timescale 1ns/1ns

module fetchTop (
   input  logic          gclk,
   input  logic          grst,
   output ifPkg::addrT   wbAdr,
   output logic          wbCyc,
   output logic          wbStb,
   input  ifPkg::wordT   wbDatIn,
   input  logic          wbAck,
   input  logic          intReq,
   input  logic          intEnable,
   output ifPkg::decodeT dec,
   output logic          decValid,
   output logic          stall
);

   logic        insnStrobe;
   ifPkg::wordT insnWord;
   logic        intPending;
   logic        intTaken;

   // Wishbone read sequencer and pc
   fetchCtrl uFetchCtrl (
      .gclk       (gclk),
      .grst       (grst),
      .stall      (stall),
      .wbAck      (wbAck),
      .wbDatIn    (wbDatIn),
      .wbAdr      (wbAdr),
      .wbCyc      (wbCyc),
      .wbStb      (wbStb),
      .insnStrobe (insnStrobe),
      .insnWord   (insnWord)
   );

   // Multicycle hold, fed from decode
   stallTimer uStallTimer (
      .gclk     (gclk),
      .grst     (grst),
      .decValid (decValid),
      .opc      (dec.opc),
      .stall    (stall)
   );

   // External interrupt capture
   intLatch uIntLatch (
      .gclk       (gclk),
      .grst       (grst),
      .intReq     (intReq),
      .intEnable  (intEnable),
      .intTaken   (intTaken),
      .intPending (intPending)
   );

   // Decode register with IMM merge and injection
   instBuffer uInstBuffer (
      .gclk       (gclk),
      .grst       (grst),
      .insnStrobe (insnStrobe),
      .insnWord   (insnWord),
      .intPending (intPending),
      .dec        (dec),
      .decValid   (decValid),
      .intTaken   (intTaken)
   );

endmodule

// File: sim/fetchTb.sv
`timescale 1ns/1ns

module fetchTb;

   localparam int rows = 16;
   localparam int cycleNs = 8;
   // brali r14, 0x10 built from the ISA fields
   localparam logic [31:0] intWord = {6'o56, 5'd14, 5'd12, 16'h0010};
   // addi r0, r0, 0 beyond the end of the program
   localparam logic [31:0] nopWord = 32'h2000_0000;

   logic          gclk;
   logic          grst;
   logic [31:0]   wbAdr;
   logic          wbCyc;
   logic          wbStb;
   logic [31:0]   wbDatIn;
   logic          wbAck;
   logic          intReq;
   logic          intEnable;
   ifPkg::decodeT dec;
   logic          decValid;
   logic          stall;

   // Program table of word, interrupt mode and expected simm
   // Mode 0 is none, 1 raises with enable high and 2 raises with enable low
   logic [31:0] wordTbl [rows];
   logic [1:0]  modeTbl [rows];
   logic [31:0] simmTbl [rows];

   int errors;
   int decCount;

   fetchTop UUT (
      .gclk      (gclk),
      .grst      (grst),
      .wbAdr     (wbAdr),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbDatIn   (wbDatIn),
      .wbAck     (wbAck),
      .intReq    (intReq),
      .intEnable (intEnable),
      .dec       (dec),
      .decValid  (decValid),
      .stall     (stall)
   );

   initial begin
      gclk = 1'b0;
      forever #(cycleNs / 2) gclk = ~gclk;
   end

   task automatic addRow(input int i, input logic [5:0] opc, input logic [15:0] imm,
                         input logic [1:0] mode, input logic [31:0] simm);
      // rd follows the row number and ra is always r1
      wordTbl[i] = {opc, i[4:0], 5'd1, imm};
      modeTbl[i] = mode;
      simmTbl[i] = simm;
   endtask

   task automatic reportMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   // Wishbone slave with random wait states
   initial begin : wbSlave
      logic [31:0] expAdr;
      logic [31:0] heldAdr;
      int          waitLeft;
      int          slot;
      bit          inReq;
      expAdr   = 32'h0;
      heldAdr  = 32'h0;
      waitLeft = 0;
      slot     = 0;
      inReq    = 1'b0;
      @(negedge grst);
      forever begin
         @(posedge gclk);
         #1;
         if (wbAck) begin
            wbAck = 1'b0;
         end else if (wbCyc && wbStb) begin
            if (!inReq) begin
               inReq   = 1'b1;
               heldAdr = wbAdr;
               slot    = int'(wbAdr >> 2);
               if (wbAdr !== expAdr) reportMismatch("wbAdr", wbAdr, expAdr);
               waitLeft = int'($urandom % 4);
               // Interrupt needs three edges to reach pending
               if (slot < rows && modeTbl[slot] != 2'd0) waitLeft = 1 + int'($urandom % 3);
            end else if (wbAdr !== heldAdr) begin
               reportMismatch("wbAdr during wait", wbAdr, heldAdr);
            end
            if (waitLeft == 0) begin
               wbAck   = 1'b1;
               wbDatIn = (slot < rows) ? wordTbl[slot] : nopWord;
               inReq   = 1'b0;
               expAdr  = expAdr + 32'd4;
               if (intReq) begin
                  intReq    = 1'b0;
                  intEnable = 1'b1;
               end
               // Raise ahead of a flagged row
               if (slot + 1 < rows && modeTbl[slot+1] != 2'd0) begin
                  intReq    = 1'b1;
                  intEnable = (modeTbl[slot+1] == 2'd1);
               end
            end else begin
               waitLeft--;
            end
         end
      end
   end

   // Reference model and checks sampled late in the cycle
   initial begin : decodeCheck
      logic [31:0] expWord;
      logic [31:0] expSimm;
      logic [15:0] prevHi;
      logic [5:0]  opc;
      bit          modelPend;
      bit          prevImm;
      bit          prevBlock;
      bit          injected;
      bit          prevCyc;
      bit          prevStall;
      int          stallLeft;
      int          idx;
      prevHi    = 16'h0;
      modelPend = 1'b0;
      prevImm   = 1'b0;
      prevBlock = 1'b0;
      prevCyc   = 1'b0;
      prevStall = 1'b0;
      stallLeft = 0;
      idx       = 0;
      forever begin
         @(posedge gclk);
         #2;
         // cyc and stb always travel together
         if (wbStb !== wbCyc) begin
            $display("error at %0t: wbStb and wbCyc do not move together", $time);
            errors++;
         end
         if (grst) begin
            if (wbCyc || decValid || stall) begin
               $display("error at %0t: outputs not idle during reset", $time);
               errors++;
            end
         end else begin
            if ((stallLeft != 0) !== stall) reportMismatch("stall", stall, stallLeft != 0);
            if (wbCyc && !prevCyc && prevStall) begin
               $display("error at %0t: new bus request started while stalled", $time);
               errors++;
            end
            if (stallLeft != 0) stallLeft--;
            if (decValid) begin
               if (idx < rows && modeTbl[idx] == 2'd1) modelPend = 1'b1;
               injected = modelPend && !prevBlock;
               expWord  = (idx < rows) ? wordTbl[idx] : nopWord;
               if (injected) begin
                  expWord   = intWord;
                  modelPend = 1'b0;
               end
               if (prevImm) expSimm = {prevHi, expWord[15:0]};
               else expSimm = {{16{expWord[15]}}, expWord[15:0]};
               // Table column gives the simm of every word that is not displaced
               if (!injected && idx < rows && dec.simm !== simmTbl[idx]) begin
                  reportMismatch("dec.simm", dec.simm, simmTbl[idx]);
               end
               if (dec.opc !== expWord[31:26]) reportMismatch("dec.opc", dec.opc, expWord[31:26]);
               if (dec.rd !== expWord[25:21]) reportMismatch("dec.rd", dec.rd, expWord[25:21]);
               if (dec.ra !== expWord[20:16]) reportMismatch("dec.ra", dec.ra, expWord[20:16]);
               if (dec.low.f.rb !== expWord[15:11]) begin
                  reportMismatch("dec.rb", dec.low.f.rb, expWord[15:11]);
               end
               if (dec.low.f.alt !== expWord[10:0]) begin
                  reportMismatch("dec.alt", dec.low.f.alt, expWord[10:0]);
               end
               if (dec.low.imm !== expWord[15:0]) begin
                  reportMismatch("dec.imm", dec.low.imm, expWord[15:0]);
               end
               if (dec.simm !== expSimm) reportMismatch("dec.simm", dec.simm, expSimm);
               opc       = expWord[31:26];
               prevImm   = (opc == 6'o54);
               prevHi    = expWord[15:0];
               prevBlock = (opc == 6'o54) || (opc == 6'o55) || (opc == 6'o46) ||
                           (opc == 6'o56) || (opc == 6'o47) || (opc == 6'o57);
               // Multicycle ops hold fetch from the next cycle on
               if (opc == 6'o20 || opc == 6'o30) stallLeft = 3;
               else if (opc == 6'o21 || opc == 6'o31) stallLeft = 2;
               idx++;
               decCount = idx;
            end
         end
         prevCyc   = wbCyc;
         prevStall = stall;
      end
   end

   // Watchdog
   initial begin
      #((rows * 12 + 5) * cycleNs);
      $display("Timeout: only %0d of %0d instructions decoded", decCount, rows);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      void'($urandom(32));
      errors    = 0;
      decCount  = 0;
      grst      = 1'b1;
      wbDatIn   = 32'h0;
      wbAck     = 1'b0;
      intReq    = 1'b0;
      intEnable = 1'b1;
      addRow(0,  6'o10, 16'h0005, 2'd0, 32'h0000_0005);
      addRow(1,  6'o10, 16'hfff0, 2'd0, 32'hffff_fff0);
      addRow(2,  6'o54, 16'h1234, 2'd0, 32'h0000_1234);
      addRow(3,  6'o10, 16'h8001, 2'd0, 32'h1234_8001);
      addRow(4,  6'o20, 16'h2800, 2'd0, 32'h0000_2800);
      addRow(5,  6'o10, 16'h0007, 2'd1, 32'h0000_0007);
      addRow(6,  6'o10, 16'h7fff, 2'd0, 32'h0000_7fff);
      addRow(7,  6'o21, 16'h0403, 2'd0, 32'h0000_0403);
      addRow(8,  6'o56, 16'h0020, 2'd0, 32'h0000_0020);
      // Raised behind a branch so it lands one row late
      addRow(9,  6'o10, 16'h0001, 2'd1, 32'h0000_0001);
      addRow(10, 6'o10, 16'h0002, 2'd0, 32'h0000_0002);
      addRow(11, 6'o54, 16'habcd, 2'd0, 32'hffff_abcd);
      addRow(12, 6'o10, 16'h00ff, 2'd0, 32'habcd_00ff);
      addRow(13, 6'o10, 16'h0010, 2'd2, 32'h0000_0010);
      addRow(14, 6'o30, 16'hffff, 2'd0, 32'hffff_ffff);
      addRow(15, 6'o10, 16'h0003, 2'd0, 32'h0000_0003);
      repeat (5) @(posedge gclk);
      #1;
      grst = 1'b0;
      wait (decCount == rows);
      repeat (2) @(posedge gclk);
      $display("Checks done: %0d instructions decoded, %0d errors", decCount, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: src.f
source/ifPkg.sv
source/fetchCtrl.sv
source/stallTimer.sv
source/intLatch.sv
source/instBuffer.sv
source/fetchTop.sv
sim/fetchTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = fetchTb
FILELIST  = src.f
OBJDIR    = obj_dir
PASSTEXT  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
